// File: noc_params.svh
`ifndef NOC_PARAMS_SVH
`define NOC_PARAMS_SVH

////////////////////
// mesh geometry
////////////////////

// nodes per row and per column
`define NOC_X_NODES 4
`define NOC_Y_NODES 4

// coordinate field widths
`define NOC_X_W 2
`define NOC_Y_W 2

////////////////////
// router sizing
////////////////////

// local plus four compass ports
`define NOC_PORTS 5

// flit payload bits
`define NOC_DATA_W 8

// input buffers are deeper, output stage only decouples the handshake
`define NOC_IN_DEPTH  4
`define NOC_OUT_DEPTH 2

`endif

// File: noc_pkg.sv
`include "noc_params.svh"

package noc_pkg;

   ////////////////////
   // port naming
   ////////////////////

   // local first, then east, north, west, south
   typedef enum logic [2:0] {
      port_local = 3'd0,
      port_east  = 3'd1,
      port_north = 3'd2,
      port_west  = 3'd3,
      port_south = 3'd4
   } port_e;

   // one bit per port, index with port_e
   typedef logic [`NOC_PORTS-1:0] port_vec_t;

   ////////////////////
   // flit formats
   ////////////////////

   // single-flit packet as seen on the links
   typedef struct packed {
      logic [`NOC_X_W-1:0]    dest_x;
      logic [`NOC_Y_W-1:0]    dest_y;
      logic [`NOC_DATA_W-1:0] payload;
   } flit_t;

   // flit plus its output port, held in the input buffers
   typedef struct packed {
      flit_t     flit;
      port_vec_t route;
   } routed_flit_t;

endpackage

// File: route_compute.sv
`timescale 1ns/100ps
`include "noc_params.svh"

module route_compute #(
   parameter int x_pos = 0,
   parameter int y_pos = 0
) (
   input  logic [`NOC_X_W-1:0] dest_x,
   input  logic [`NOC_Y_W-1:0] dest_y,
   output noc_pkg::port_vec_t  out_port
);
   import noc_pkg::*;

   // this node's coordinates in link width
   localparam logic [`NOC_X_W-1:0] cur_x = x_pos[`NOC_X_W-1:0];
   localparam logic [`NOC_Y_W-1:0] cur_y = y_pos[`NOC_Y_W-1:0];

   // one extra bit so the difference keeps its sign
   logic signed [`NOC_X_W:0] x_diff;
   logic signed [`NOC_Y_W:0] y_diff;
   port_e                    dir;
   logic                     at_home;

   // node must lie inside the mesh
   if (x_pos >= `NOC_X_NODES || y_pos >= `NOC_Y_NODES) begin : g_bad_pos
      $error("route_compute: node (%0d,%0d) outside mesh", x_pos, y_pos);
   end

   assign x_diff  = $signed({1'b0, dest_x}) - $signed({1'b0, cur_x});
   assign y_diff  = $signed({1'b0, dest_y}) - $signed({1'b0, cur_y});
   assign at_home = (dest_x == cur_x) && (dest_y == cur_y);

   ////////////////////
   // xy routing
   ////////////////////

   // x is corrected first, y only once the column matches
   always_comb begin
      if (x_diff > 0)
         dir = port_east;
      else if (x_diff < 0)
         dir = port_west;
      else if (y_diff > 0)
         dir = port_south;
      else if (y_diff < 0)
         dir = port_north;
      else
         dir = port_local;
   end

   // encode as one-hot for the arbiters
   always_comb begin
      out_port      = '0;
      out_port[dir] = 1'b1;
   end

   // exactly one port, and local only for flits addressed here
   always_comb begin
      assert ($onehot(out_port) && (out_port[port_local] == at_home))
         else $error("route_compute: bad route %b", out_port);
   end

endmodule

// File: flit_fifo.sv
`timescale 1ns/100ps

module flit_fifo #(
   parameter type payload_t = logic [7:0],
   parameter int  depth     = 4
) (
   input  logic     clk,
   input  logic     rst,
   input  logic     push,
   input  payload_t din,
   output logic     full,
   input  logic     pop,
   output payload_t dout,
   output logic     empty
);

   // pointer width, at least one bit
   localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

   localparam logic [ptr_w-1:0] last_slot = ptr_w'(depth - 1);
   localparam logic [ptr_w:0]   max_count = (ptr_w + 1)'(depth);

   payload_t         mem [depth];
   logic [ptr_w-1:0] rd_ptr;
   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w:0]   count;

   assign full  = (count == max_count);
   assign empty = (count == '0);

   // head is always visible
   assign dout = mem[rd_ptr];

   ////////////////////
   // storage
   ////////////////////

   always_ff @(posedge clk) begin
      if (push)
         mem[wr_ptr] <= din;
   end

   ////////////////////
   // pointers and fill level
   ////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end else begin
         // wrap by compare, depth need not be a power of two
         if (push)
            wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
         if (push && !pop)
            count <= count + 1'b1;
         else if (pop && !push)
            count <= count - 1'b1;
      end
   end

   // callers must respect full and empty
   a_no_overflow : assert property (@(posedge clk) disable iff (rst) !(push && full))
      else $error("flit_fifo: push while full");

   a_no_underflow : assert property (@(posedge clk) disable iff (rst) !(pop && empty))
      else $error("flit_fifo: pop while empty");

endmodule

// File: port_arbiter.sv
`timescale 1ns/100ps
`include "noc_params.svh"

module port_arbiter (
   input  logic               clk,
   input  logic               rst,
   input  noc_pkg::port_vec_t req,
   input  logic               enable,
   output noc_pkg::port_vec_t grant
);
   import noc_pkg::*;

   // input with highest priority this cycle
   port_e ptr;
   port_e next_ptr;

   ////////////////////
   // round-robin pick
   ////////////////////

   // scan from ptr upward, first requester wins
   always_comb begin
      int   idx;
      logic found;
      idx      = 0;
      found    = 1'b0;
      grant    = '0;
      next_ptr = ptr;
      for (int k = 0; k < `NOC_PORTS; k++) begin
         idx = (int'(ptr) + k) % `NOC_PORTS;
         if (enable && !found && req[idx]) begin
            grant[idx] = 1'b1;
            found      = 1'b1;
            // winner drops to lowest priority
            next_ptr   = port_e'(3'((idx + 1) % `NOC_PORTS));
         end
      end
   end

   ////////////////////
   // priority pointer
   ////////////////////

   always_ff @(posedge clk) begin
      if (rst)
         ptr <= port_local;
      else if (|grant)
         ptr <= next_ptr;
   end

   // at most one winner, and only among requesters
   a_grant_ok : assert property (@(posedge clk) disable iff (rst)
      $onehot0(grant) && ((grant & ~req) == '0))
      else $error("port_arbiter: bad grant %b for req %b", grant, req);

endmodule

// File: mesh_router.sv
`timescale 1ns/100ps
`include "noc_params.svh"

module mesh_router #(
   parameter int x_pos = 0,
   parameter int y_pos = 0
) (
   input  logic                   clk,
   input  logic                   rst,
   input  logic [`NOC_PORTS-1:0]  in_req,
   output logic [`NOC_PORTS-1:0]  in_ack,
   input  noc_pkg::flit_t         in_flit [`NOC_PORTS],
   output logic [`NOC_PORTS-1:0]  out_req,
   input  logic [`NOC_PORTS-1:0]  out_ack,
   output noc_pkg::flit_t         out_flit [`NOC_PORTS]
);
   import noc_pkg::*;

   // input side
   port_vec_t    in_route  [`NOC_PORTS];
   routed_flit_t in_din    [`NOC_PORTS];
   routed_flit_t in_head   [`NOC_PORTS];
   logic [`NOC_PORTS-1:0] in_push;
   logic [`NOC_PORTS-1:0] in_pop;
   logic [`NOC_PORTS-1:0] in_full;
   logic [`NOC_PORTS-1:0] in_empty;

   // arb_* is indexed by output and grant_by_in by input
   port_vec_t arb_req     [`NOC_PORTS];
   port_vec_t arb_grant   [`NOC_PORTS];
   port_vec_t grant_by_in [`NOC_PORTS];

   // output side
   flit_t                 out_din [`NOC_PORTS];
   logic [`NOC_PORTS-1:0] out_push;
   logic [`NOC_PORTS-1:0] out_pop;
   logic [`NOC_PORTS-1:0] out_full;
   logic [`NOC_PORTS-1:0] out_empty;

   ////////////////////
   // input stages
   ////////////////////

   for (genvar p = 0; p < `NOC_PORTS; p++) begin : g_in
      // route decided before buffering
      route_compute #(
         .x_pos (x_pos),
         .y_pos (y_pos)
      ) i_route (
         .dest_x   (in_flit[p].dest_x),
         .dest_y   (in_flit[p].dest_y),
         .out_port (in_route[p])
      );

      assign in_din[p].flit  = in_flit[p];
      assign in_din[p].route = in_route[p];

      // capture once per req, and only with room
      assign in_push[p] = in_req[p] && !in_ack[p] && !in_full[p];

      // four-phase slave side
      always_ff @(posedge clk) begin
         if (rst)
            in_ack[p] <= 1'b0;
         else if (in_push[p])
            in_ack[p] <= 1'b1;
         else if (in_ack[p] && !in_req[p])
            in_ack[p] <= 1'b0;
      end

      flit_fifo #(
         .payload_t (routed_flit_t),
         .depth     (`NOC_IN_DEPTH)
      ) i_in_fifo (
         .clk   (clk),
         .rst   (rst),
         .push  (in_push[p]),
         .din   (in_din[p]),
         .full  (in_full[p]),
         .pop   (in_pop[p]),
         .dout  (in_head[p]),
         .empty (in_empty[p])
      );

      // head leaves when any output takes it
      assign in_pop[p] = |grant_by_in[p];

      // a head names one output, so only one arbiter may take it
      a_single_pop : assert property (@(posedge clk) disable iff (rst)
         $onehot0(grant_by_in[p]))
         else $error("mesh_router: input %0d granted by several outputs", p);
   end

   // column o of the request matrix gathers heads routed to o
   always_comb begin
      for (int o = 0; o < `NOC_PORTS; o++) begin
         for (int i = 0; i < `NOC_PORTS; i++) begin
            arb_req[o][i] = !in_empty[i] && in_head[i].route[o];
         end
      end
   end

   // the same grants seen from the input side
   always_comb begin
      for (int i = 0; i < `NOC_PORTS; i++) begin
         for (int o = 0; o < `NOC_PORTS; o++) begin
            grant_by_in[i][o] = arb_grant[o][i];
         end
      end
   end

   ////////////////////
   // arbiters and crossbar
   ////////////////////

   for (genvar o = 0; o < `NOC_PORTS; o++) begin : g_out
      // no grant while the output buffer is full
      port_arbiter i_arb (
         .clk    (clk),
         .rst    (rst),
         .req    (arb_req[o]),
         .enable (!out_full[o]),
         .grant  (arb_grant[o])
      );

      // grant is one-hot, so an or of masked heads selects
      always_comb begin
         out_din[o] = '0;
         for (int i = 0; i < `NOC_PORTS; i++) begin
            if (arb_grant[o][i])
               out_din[o] = out_din[o] | in_head[i].flit;
         end
      end

      assign out_push[o] = |arb_grant[o];

      flit_fifo #(
         .payload_t (flit_t),
         .depth     (`NOC_OUT_DEPTH)
      ) i_out_fifo (
         .clk   (clk),
         .rst   (rst),
         .push  (out_push[o]),
         .din   (out_din[o]),
         .full  (out_full[o]),
         .pop   (out_pop[o]),
         .dout  (out_flit[o]),
         .empty (out_empty[o])
      );

      // head retires on the ack edge
      assign out_pop[o] = out_req[o] && out_ack[o];

      // four-phase master side waits for ack low before the next flit
      always_ff @(posedge clk) begin
         if (rst)
            out_req[o] <= 1'b0;
         else if (out_pop[o])
            out_req[o] <= 1'b0;
         else if (!out_req[o] && !out_empty[o] && !out_ack[o])
            out_req[o] <= 1'b1;
      end
   end

endmodule

// File: tb_mesh_router.sv
`timescale 1ns/100ps
`include "noc_params.svh"

module tb_mesh_router;
   import noc_pkg::*;

   // node under test sits at column 1, row 2
   localparam int node_x      = 1;
   localparam int node_y      = 2;
   localparam int burst_len   = 6;
   localparam int bp_max      = 12;
   // routing sweep, all-input bursts, contention bursts, back-pressure fill
   localparam int total_flits = `NOC_X_NODES * `NOC_Y_NODES + 9 * burst_len + bp_max;

   logic                  clk;
   logic                  rst;
   logic [`NOC_PORTS-1:0] in_req;
   logic [`NOC_PORTS-1:0] in_ack;
   flit_t                 in_flit [`NOC_PORTS];
   logic [`NOC_PORTS-1:0] out_req;
   logic [`NOC_PORTS-1:0] out_ack = '0;
   flit_t                 out_flit [`NOC_PORTS];

   // receiver leaves an output unanswered while its bit is set
   logic [`NOC_PORTS-1:0] hold;
   logic [31:0]           lfsr = 32'd88022;
   int                    seq [`NOC_PORTS];
   // expected flits per input and output pair in send order
   flit_t                 exp_q [`NOC_PORTS][`NOC_PORTS][$];
   // inputs served at an output while another input waited
   logic [`NOC_PORTS-1:0] served [`NOC_PORTS][`NOC_PORTS];

   string test_name = "none";
   int    tests;
   int    checks;
   int    errors;
   int    test_checks;
   int    test_errors;

   mesh_router #(
      .x_pos (node_x),
      .y_pos (node_y)
   ) i_dut (
      .clk      (clk),
      .rst      (rst),
      .in_req   (in_req),
      .in_ack   (in_ack),
      .in_flit  (in_flit),
      .out_req  (out_req),
      .out_ack  (out_ack),
      .out_flit (out_flit)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // bound of 40 cycles per flit
   initial begin
      repeat (total_flits * 40) @(posedge clk);
      $display("watchdog: tests did not finish within %0d cycles", total_flits * 40);
      $display("Something failed");
      $finish;
   end

   ////////////////////
   // helpers
   ////////////////////

   // galois lfsr stepped once per bit
   function automatic logic [31:0] lfsr_bits(input int n);
      logic [31:0] r;
      logic        b;
      r = '0;
      for (int k = 0; k < n; k++) begin
         b    = lfsr[0];
         lfsr = lfsr >> 1;
         if (b)
            lfsr = lfsr ^ 32'h8020_0003;
         r = {r[30:0], b};
      end
      return r;
   endfunction

   // x first, then y
   function automatic int expected_port(input int dx, input int dy);
      if (dx > node_x)
         return int'(port_east);
      if (dx < node_x)
         return int'(port_west);
      if (dy > node_y)
         return int'(port_south);
      if (dy < node_y)
         return int'(port_north);
      return int'(port_local);
   endfunction

   // payload = source input and sequence number
   function automatic flit_t make_flit(input int p, input int dx, input int dy);
      flit_t f;
      f.dest_x  = `NOC_X_W'(dx);
      f.dest_y  = `NOC_Y_W'(dy);
      f.payload = {3'(p), 5'(seq[p])};
      seq[p]++;
      return f;
   endfunction

   function automatic int outstanding_flits();
      int n;
      n = 0;
      for (int i = 0; i < `NOC_PORTS; i++)
         for (int o = 0; o < `NOC_PORTS; o++)
            n += exp_q[i][o].size();
      return n;
   endfunction

   task automatic check_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks++;
      assert (expected === actual)
         else begin
            errors++;
            $display("mismatch %s %s: expected %0h actual %0h", test_name, what,
                     expected, actual);
         end
   endtask

   task automatic check_true(input bit cond, input string msg);
      checks++;
      assert (cond)
         else begin
            errors++;
            $display("error in %s: %s", test_name, msg);
         end
   endtask

   task automatic check_arrival(input int o, input flit_t f);
      int    src;
      flit_t want;
      src = int'(f.payload[7:5]);
      check_value("port", expected_port(int'(f.dest_x), int'(f.dest_y)), o);
      if (src >= `NOC_PORTS || exp_q[src][o].size() == 0) begin
         check_true(1'b0, $sformatf("unexpected flit %h at output %0d", f, o));
      end else begin
         want = exp_q[src][o].pop_front();
         check_value("flit", 32'(want), 32'(f));
      end
   endtask

   // inputs change 1 ns after the edge
   task automatic tick();
      @(posedge clk);
      #1;
   endtask

   task automatic raise_req(input int p, input flit_t f);
      while (in_ack[p])
         tick();
      in_flit[p] = f;
      in_req[p]  = 1'b1;
      exp_q[p][expected_port(int'(f.dest_x), int'(f.dest_y))].push_back(f);
   endtask

   task automatic wait_ack(input int p, input int limit, output bit got);
      int n;
      n = 0;
      while (!in_ack[p] && n < limit) begin
         tick();
         n++;
      end
      got = in_ack[p];
   endtask

   task automatic send_flit(input int p, input flit_t f);
      tick();
      raise_req(p, f);
      while (!in_ack[p])
         tick();
      in_req[p] = 1'b0;
   endtask

   task automatic send_burst(input int p, input int n, input bit to_local);
      for (int k = 0; k < n; k++) begin
         if (to_local)
            send_flit(p, make_flit(p, node_x, node_y));
         else
            send_flit(p, make_flit(p, int'(lfsr_bits(2)), int'(lfsr_bits(2))));
      end
   endtask

   task automatic wait_drain();
      while (outstanding_flits() != 0)
         tick();
      repeat (4) tick();
   endtask

   task automatic start_test(input string name);
      test_name   = name;
      test_checks = checks;
      test_errors = errors;
   endtask

   task automatic end_test();
      tests++;
      $display("test %-12s %0d checks, %0d errors", test_name, checks - test_checks,
               errors - test_errors);
   endtask

   ////////////////////
   // output receivers
   ////////////////////

   // four-phase slave on every output that samples 1 ns after the edge
   always @(posedge clk) begin
      #1;
      for (int o = 0; o < `NOC_PORTS; o++) begin
         if (rst) begin
            out_ack[o] = 1'b0;
         end else if (out_ack[o] && !out_req[o]) begin
            out_ack[o] = 1'b0;
         end else if (!out_ack[o] && out_req[o] && !hold[o]) begin
            check_arrival(o, out_flit[o]);
            out_ack[o] = 1'b1;
         end
      end
   end

   // mid-cycle fairness check on settled requests and grants
   always @(negedge clk) begin
      for (int o = 0; o < `NOC_PORTS; o++) begin
         for (int j = 0; j < `NOC_PORTS; j++) begin
            if (rst || !i_dut.arb_req[o][j] || i_dut.arb_grant[o][j]) begin
               served[o][j] = '0;
            end else begin
               for (int i = 0; i < `NOC_PORTS; i++) begin
                  if (i_dut.arb_grant[o][i]) begin
                     check_true(!served[o][j][i], $sformatf(
                        "input %0d served twice at output %0d while input %0d waited",
                        i, o, j));
                     served[o][j][i] = 1'b1;
                  end
               end
            end
         end
      end
   end

   ////////////////////
   // handshake rules
   ////////////////////

   for (genvar p = 0; p < `NOC_PORTS; p++) begin : g_proto
      a_req_held : assert property (@(posedge clk) disable iff (rst)
         out_req[p] && !out_ack[p] |=> out_req[p])
         else begin
            errors++;
            $display("protocol: out_req %0d dropped before out_ack", p);
         end

      a_flit_stable : assert property (@(posedge clk) disable iff (rst)
         out_req[p] |=> !out_req[p] || $stable(out_flit[p]))
         else begin
            errors++;
            $display("protocol: out_flit %0d changed while out_req was high", p);
         end

      a_ack_on_req : assert property (@(posedge clk) disable iff (rst)
         $rose(in_ack[p]) |-> $past(in_req[p]))
         else begin
            errors++;
            $display("protocol: in_ack %0d rose without in_req", p);
         end
   end

   ////////////////////
   // test sequence
   ////////////////////

   initial begin : main_seq
      int accepted;
      bit stalled;
      bit got;
      in_req = '0;
      hold   = '0;
      rst    = 1'b1;
      for (int p = 0; p < `NOC_PORTS; p++) begin
         in_flit[p] = '0;
         seq[p]     = 0;
      end
      repeat (5) @(posedge clk);
      #1 rst = 1'b0;

      start_test("reset");
      check_value("in_ack", 0, 32'(in_ack));
      check_value("out_req", 0, 32'(out_req));
      end_test();

      // local port sends to every node of the mesh
      start_test("routing");
      for (int dx = 0; dx < `NOC_X_NODES; dx++)
         for (int dy = 0; dy < `NOC_Y_NODES; dy++)
            send_flit(int'(port_local), make_flit(int'(port_local), dx, dy));
      wait_drain();
      end_test();

      start_test("ordering");
      fork
         send_burst(0, burst_len, 1'b0);
         send_burst(1, burst_len, 1'b0);
         send_burst(2, burst_len, 1'b0);
         send_burst(3, burst_len, 1'b0);
         send_burst(4, burst_len, 1'b0);
      join
      wait_drain();
      end_test();

      // compass inputs all aim at this node
      start_test("contention");
      fork
         send_burst(1, burst_len, 1'b1);
         send_burst(2, burst_len, 1'b1);
         send_burst(3, burst_len, 1'b1);
         send_burst(4, burst_len, 1'b1);
      join
      wait_drain();
      end_test();

      // local input fills both buffers while east is held
      start_test("backpressure");
      hold[int'(port_east)] = 1'b1;
      accepted = 0;
      stalled  = 1'b0;
      while (!stalled && accepted < bp_max) begin
         tick();
         raise_req(int'(port_local), make_flit(int'(port_local), 3, int'(lfsr_bits(2))));
         wait_ack(int'(port_local), 20, got);
         if (got) begin
            in_req[int'(port_local)] = 1'b0;
            accepted++;
         end else begin
            stalled = 1'b1;
         end
      end
      check_true(stalled, "in_ack kept answering while the east output was held");
      check_value("accepted", `NOC_IN_DEPTH + `NOC_OUT_DEPTH, accepted);
      hold[int'(port_east)] = 1'b0;
      if (stalled) begin
         while (!in_ack[int'(port_local)])
            tick();
         in_req[int'(port_local)] = 1'b0;
      end
      wait_drain();
      end_test();

      $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

// File: sources.f
+incdir+.
noc_pkg.sv
route_compute.sv
flit_fifo.sv
port_arbiter.sv
mesh_router.sv
tb_mesh_router.sv

// File: Makefile
TOP := tb_mesh_router

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f sources.f

# pass only when the run prints the pass line
sim:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Everything OK$$"

clean:
	rm -rf obj_dir
